/* Makefile */
TOP = synthesizer_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "CHECKS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* midi_parser.sv */
/*
 * MIDI byte FSM: channel note-on / note-off with running status,
 * plus F0 addr data F7 sysex that issues one patch write
 */
`timescale 1ns/1ps
`include "synth_cfg.svh"

module midi_parser (
    input  logic                 reg_clk,
    input  logic                 arst_n,
    input  logic [7:0]           midi_byte,
    input  logic                 midi_valid,
    input  logic [3:0]           midi_ch,
    output synth_pkg::note_evt_t note,
    output logic                 note_valid,
    output synth_pkg::reg_req_t  syx_req,
    output logic                 syx_valid
);

    synth_pkg::midi_state_t state;

    logic       is_rt;      // F8..FF realtime, passes through untouched
    logic       is_status;
    logic       ch_note;    // 8n / 9n for our channel
    logic       run_on;     // 1 = note-on status is running
    logic [6:0] key_r;
    logic [6:0] sx_addr;
    logic [7:0] sx_data;

    assign is_rt     = (midi_byte[7:3] == 5'b11111);
    assign is_status = midi_byte[7] & ~is_rt;
    assign ch_note   = (midi_byte[7:5] == 3'b100) && (midi_byte[3:0] == midi_ch);

    // sysex always writes, never reads
    assign syx_req = '{write: 1'b1, read: 1'b0, addr: sx_addr, data: sx_data};

    ////////////////////
    // control
    always_ff @(posedge reg_clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= synth_pkg::MS_IDLE;
            note_valid <= 1'b0;
            syx_valid  <= 1'b0;
        end else begin
            note_valid <= 1'b0;   // strobes
            syx_valid  <= 1'b0;
            if (midi_valid && is_status) begin
                if (ch_note) begin
                    state <= synth_pkg::MS_KEY;
                end else if (midi_byte == 8'hF0) begin
                    state <= synth_pkg::MS_SYX_ADDR;
                end else begin
                    // F7 only counts after addr and data, anything else drops status
                    if (midi_byte == 8'hF7 && state == synth_pkg::MS_SYX_END)
                        syx_valid <= 1'b1;
                    state <= synth_pkg::MS_IDLE;
                end
            end else if (midi_valid && !midi_byte[7]) begin
                case (state)
                    synth_pkg::MS_KEY:      state <= synth_pkg::MS_VEL;
                    synth_pkg::MS_VEL: begin
                        note_valid <= 1'b1;
                        state      <= synth_pkg::MS_KEY;  // running status
                    end
                    synth_pkg::MS_SYX_ADDR: state <= synth_pkg::MS_SYX_DATA;
                    synth_pkg::MS_SYX_DATA: state <= synth_pkg::MS_SYX_END;
                    default:                state <= synth_pkg::MS_IDLE; // stray / overlong
                endcase
            end
        end
    end

    ////////////////////
    // payload capture
    always_ff @(posedge reg_clk) begin
        if (midi_valid) begin
            if (ch_note)
                run_on <= midi_byte[4];   // 9n sets, 8n clears
            if (!midi_byte[7]) begin
                case (state)
                    synth_pkg::MS_KEY: key_r <= midi_byte[6:0];
                    synth_pkg::MS_VEL: begin
                        note.on  <= run_on & (|midi_byte[6:0]);  // vel 0 = off
                        note.key <= key_r;
                        note.vel <= midi_byte[6:0];
                    end
                    synth_pkg::MS_SYX_ADDR: sx_addr <= midi_byte[6:0];
                    synth_pkg::MS_SYX_DATA: sx_data <= {1'b0, midi_byte[6:0]};
                    default: ;
                endcase
            end
        end
    end

endmodule

/* patch_regs.sv */
/*
 * patch register file, write decode and registered read-back
 * map: 0 wave, 1 level, 2 left_gain, 3 right_gain, 4 midi_ch
 */
`timescale 1ns/1ps
`include "synth_cfg.svh"

module patch_regs (
    input  logic                reg_clk,
    input  logic                arst_n,
    input  synth_pkg::reg_req_t bus_req,
    input  logic                bus_valid,
    output logic [7:0]          readdata,
    output synth_pkg::patch_t   patch
);

    localparam logic [`SYN_ADDR_BITS-1:0] ADDR_WAVE  = 'd0;
    localparam logic [`SYN_ADDR_BITS-1:0] ADDR_LEVEL = 'd1;
    localparam logic [`SYN_ADDR_BITS-1:0] ADDR_LGAIN = 'd2;
    localparam logic [`SYN_ADDR_BITS-1:0] ADDR_RGAIN = 'd3;
    localparam logic [`SYN_ADDR_BITS-1:0] ADDR_CH    = 'd4;

    logic [7:0] rd_mux;

    always_comb begin
        case (bus_req.addr)
            ADDR_WAVE:  rd_mux = {7'd0, patch.wave};
            ADDR_LEVEL: rd_mux = patch.level;
            ADDR_LGAIN: rd_mux = patch.left_gain;
            ADDR_RGAIN: rd_mux = patch.right_gain;
            ADDR_CH:    rd_mux = {4'd0, patch.midi_ch};
            default:    rd_mux = 8'd0;   // unmapped
        endcase
    end

    always_ff @(posedge reg_clk or negedge arst_n) begin
        if (!arst_n) begin
            patch.wave       <= synth_pkg::WAVE_SQUARE;
            patch.level      <= 8'h80;
            patch.left_gain  <= 8'hFF;
            patch.right_gain <= 8'hFF;
            patch.midi_ch    <= 4'd0;
            readdata         <= 8'd0;
        end else if (bus_valid) begin
            if (bus_req.read)
                readdata <= rd_mux;    // held until next read
            if (bus_req.write) begin
                case (bus_req.addr)
                    ADDR_WAVE:  patch.wave       <= synth_pkg::wave_t'(bus_req.data[0]);
                    ADDR_LEVEL: patch.level      <= bus_req.data;
                    ADDR_LGAIN: patch.left_gain  <= bus_req.data;
                    ADDR_RGAIN: patch.right_gain <= bus_req.data;
                    ADDR_CH:    patch.midi_ch    <= bus_req.data[3:0];
                    default: ;               // writes outside the map dropped
                endcase
            end
        end
    end

endmodule

/* project.f */
+incdir+.
synth_pkg.sv
midi_parser.sv
voice_allocator.sv
reg_bus_arbiter.sv
patch_regs.sv
voice_engine.sv
synthesizer.sv
tb_clock.sv
synthesizer_props.sv
synthesizer_tb.sv

/* reg_bus_arbiter.sv */
/*
 * patch bus arbiter, cpu over sysex
 * a colliding sysex write waits one cycle in a single pending entry
 */
`timescale 1ns/1ps
`include "synth_cfg.svh"

module reg_bus_arbiter (
    input  logic                reg_clk,
    input  logic                arst_n,
    input  synth_pkg::reg_req_t cpu_req,
    input  synth_pkg::reg_req_t syx_req,
    input  logic                syx_valid,
    output synth_pkg::reg_req_t bus_req,
    output logic                bus_valid
);

    synth_pkg::reg_req_t pend_req;
    logic                pend_valid;
    logic                cpu_valid;
    logic                grant_cpu;
    logic                grant_syx;   // pending or fresh sysex

    assign cpu_valid = cpu_req.write | cpu_req.read;
    assign grant_cpu = cpu_valid;
    assign grant_syx = ~cpu_valid & (pend_valid | syx_valid);
    assign bus_valid = grant_cpu | grant_syx;

    // grant mux, pending entry goes before a fresh sysex
    always_comb begin
        if (grant_cpu)
            bus_req = cpu_req;
        else if (pend_valid)
            bus_req = pend_req;
        else if (syx_valid)
            bus_req = syx_req;
        else
            bus_req = '0;
    end

    always_ff @(posedge reg_clk or negedge arst_n) begin
        if (!arst_n)
            pend_valid <= 1'b0;
        else if (cpu_valid && syx_valid)
            pend_valid <= 1'b1;       // collision, park it
        else if (grant_syx)
            pend_valid <= 1'b0;       // drained (or never set)
    end

    always_ff @(posedge reg_clk) begin
        if (cpu_valid && syx_valid)
            pend_req <= syx_req;
    end

endmodule

/* synth_cfg.svh */
/*
 * build-time constants for the tone generator
 * voice count, audio and phase widths, patch address width
 */
`ifndef SYNTH_CFG_SVH
`define SYNTH_CFG_SVH

`define SYN_VOICES      8   // polyphony
`define SYN_V_WIDTH     3   // voice index bits
`define SYN_AUD_BITS    24  // output sample width
`define SYN_PHASE_BITS  16  // per-voice accumulator
`define SYN_PHASE_SHIFT 6   // key number << this = phase increment

// patch bus
`define SYN_ADDR_BITS   7

`endif

/* synth_pkg.sv */
/*
 * shared types: note events, patch-bus requests, live patch,
 * wave select and the parser / engine state encodings
 */
`include "synth_cfg.svh"

package synth_pkg;

    // one note message, parser -> allocator
    typedef struct packed {
        logic       on;
        logic [6:0] key;
        logic [6:0] vel;
    } note_evt_t;

    // one patch-bus access (cpu, sysex, granted)
    typedef struct packed {
        logic                      write;
        logic                      read;
        logic [`SYN_ADDR_BITS-1:0] addr;
        logic [7:0]                data;
    } reg_req_t;

    typedef enum logic [0:0] {
        WAVE_SQUARE = 1'b0,
        WAVE_SAW    = 1'b1
    } wave_t;

    // live patch, register file -> engine and parser
    typedef struct packed {
        wave_t      wave;
        logic [7:0] level;
        logic [7:0] left_gain;
        logic [7:0] right_gain;
        logic [3:0] midi_ch;
    } patch_t;

    typedef enum logic [2:0] {
        MS_IDLE,
        MS_KEY,       // waiting for key byte, also running status
        MS_VEL,
        MS_SYX_ADDR,
        MS_SYX_DATA,
        MS_SYX_END    // only F7 accepted here
    } midi_state_t;

    typedef enum logic [1:0] {
        ES_IDLE,
        ES_VOICE,
        ES_OUT
    } eng_state_t;

endpackage

/* synthesizer.sv */
/*
 * tone generator top: parser, allocator, bus arbiter,
 * patch registers and voice engine
 */
`timescale 1ns/1ps
`include "synth_cfg.svh"

module synthesizer (
    input  logic                      reg_clk,
    input  logic                      arst_n,
    input  logic [7:0]                midi_byte,
    input  logic                      midi_valid,
    input  logic                      cpu_write,
    input  logic                      cpu_read,
    input  logic [`SYN_ADDR_BITS-1:0] address,
    input  logic [7:0]                cpu_writedata,
    input  logic                      trig,
    output logic [7:0]                cpu_readdata,
    output logic [`SYN_VOICES-1:0]    keys_on,
    output logic [`SYN_V_WIDTH:0]     active_keys,
    output logic [`SYN_AUD_BITS-1:0]  lsound_out,
    output logic [`SYN_AUD_BITS-1:0]  rsound_out,
    output logic                      frame_done
);

    synth_pkg::note_evt_t               note;
    synth_pkg::reg_req_t                cpu_req, syx_req, bus_req;
    synth_pkg::patch_t                  patch;
    logic                               note_valid, syx_valid, bus_valid;
    logic [`SYN_VOICES-1:0][6:0]        key_tab, vel_tab;

    // cpu strobes as one bus request
    assign cpu_req = '{write: cpu_write, read: cpu_read, addr: address, data: cpu_writedata};

    midi_parser u_parser (
        .reg_clk, .arst_n, .midi_byte, .midi_valid,
        .midi_ch (patch.midi_ch),                 // channel filter from patch
        .note, .note_valid, .syx_req, .syx_valid
    );

    voice_allocator u_alloc (
        .reg_clk, .arst_n, .note, .note_valid,
        .keys_on, .active_keys, .key_tab, .vel_tab
    );

    reg_bus_arbiter u_arb (
        .reg_clk, .arst_n, .cpu_req, .syx_req, .syx_valid, .bus_req, .bus_valid
    );

    patch_regs u_regs (
        .reg_clk, .arst_n, .bus_req, .bus_valid,
        .readdata (cpu_readdata), .patch
    );

    voice_engine u_engine (
        .reg_clk, .arst_n, .trig, .keys_on, .key_tab, .vel_tab, .patch,
        .lsound_out, .rsound_out, .frame_done
    );

endmodule

/* synthesizer_props.sv */
/*
 * concurrent checks on the patch bus arbiter and the frame sequencer
 */
`timescale 1ns/1ps
`include "synth_cfg.svh"

module synthesizer_props (
    input logic                  reg_clk,
    input logic                  arst_n,
    input logic                  trig,
    input logic                  frame_done,
    input synth_pkg::eng_state_t eng_state,
    input synth_pkg::reg_req_t   cpu_req,
    input synth_pkg::reg_req_t   bus_req,
    input logic                  bus_valid,
    input logic                  pend_valid,
    input logic                  syx_valid
);

    // a cpu cycle puts the cpu request on the bus, no sysex mixed in
    a_one_grant: assert property (@(posedge reg_clk) disable iff (!arst_n)
        (cpu_req.write || cpu_req.read) |-> (bus_valid && bus_req == cpu_req))
        else $error("patch bus did not carry the cpu request alone");

    // fresh sysex while one is parked would clobber the entry
    a_pend_kept: assert property (@(posedge reg_clk) disable iff (!arst_n)
        pend_valid |-> !syx_valid)
        else $error("pending sysex entry overwritten");

    a_done_pulse: assert property (@(posedge reg_clk) disable iff (!arst_n)
        frame_done |=> !frame_done)
        else $error("frame_done wider than one cycle");

    // accepted trig only, a trig mid-frame is dropped
    a_done_lat: assert property (@(posedge reg_clk) disable iff (!arst_n)
        (trig && eng_state == synth_pkg::ES_IDLE) |-> ##(`SYN_VOICES + 2) frame_done)
        else $error("frame_done not at trig + voices + 2");

endmodule

bind synthesizer synthesizer_props u_props (
    .reg_clk,
    .arst_n,
    .trig,
    .frame_done,
    .eng_state  (u_engine.state),
    .cpu_req,
    .bus_req,
    .bus_valid,
    .pend_valid (u_arb.pend_valid),
    .syx_valid
);

/* synthesizer_tb.sv */
/*
 * directed tests for the tone generator: patch registers, note allocation,
 * sysex writes and square / saw frames against a small reference model
 */
`timescale 1ns/1ps
`include "synth_cfg.svh"

module synthesizer_tb;

    localparam int NV = `SYN_VOICES;
    // reset + rough cycles per test, doubled for the limit
    localparam int EST_CYCLES = 10 + 20 + 50 + 170 + 50 + 180 + 140;
    localparam int MAX_CYCLES = 2 * EST_CYCLES;

    logic                      reg_clk;
    logic                      arst_n;
    logic [7:0]                midi_byte;
    logic                      midi_valid;
    logic                      cpu_write;
    logic                      cpu_read;
    logic [`SYN_ADDR_BITS-1:0] address;
    logic [7:0]                cpu_writedata;
    logic                      trig;
    logic [7:0]                cpu_readdata;
    logic [NV-1:0]             keys_on;
    logic [`SYN_V_WIDTH:0]     active_keys;
    logic [`SYN_AUD_BITS-1:0]  lsound_out;
    logic [`SYN_AUD_BITS-1:0]  rsound_out;
    logic                      frame_done;

    // reference model
    logic [7:0]  preg [5];      // 0 wave, 1 level, 2 lgain, 3 rgain, 4 channel
    logic        mon  [NV];
    logic [6:0]  mkey [NV];
    logic [6:0]  mvel [NV];
    logic [15:0] mph  [NV];     // phase per voice
    logic [7:0]  run_status;
    integer      seed = 26623;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          err_mark = 0;

    tb_clock u_clk (.clk(reg_clk), .arst_n);

    synthesizer UUT (.*);

    always @(posedge reg_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////
    // helpers
    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        $display("%s finished, %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    function automatic logic [6:0] random_velocity();
        logic [6:0] v;
        v = 7'($random(seed));
        return (v == 7'd0) ? 7'd1 : v;   // zero would be a note-off
    endfunction

    function automatic void model_reg_write(input logic [6:0] a, input logic [7:0] d);
        case (a)
            7'd0:             preg[0] = {7'd0, d[0]};
            7'd1, 7'd2, 7'd3: preg[a] = d;
            7'd4:             preg[4] = {4'd0, d[3:0]};
            default: ;        // unmapped
        endcase
    endfunction

    // lowest free voice, duplicates and overflow dropped
    function automatic void track_note(input logic [6:0] key, input logic [6:0] vel);
        int hit_v;
        int free_v;
        hit_v  = -1;
        free_v = -1;
        if (run_status[7:5] != 3'b100 || run_status[3:0] != preg[4][3:0])
            return;           // no status or other channel
        for (int v = NV - 1; v >= 0; v--) begin
            if (mon[v] && mkey[v] == key)
                hit_v = v;
            if (!mon[v])
                free_v = v;
        end
        if (run_status[4] && vel != 7'd0) begin
            if (hit_v < 0 && free_v >= 0) begin
                mon[free_v]  = 1'b1;
                mkey[free_v] = key;
                mvel[free_v] = vel;
            end
        end else if (hit_v >= 0) begin
            mon[hit_v] = 1'b0;
        end
    endfunction

    task automatic send_byte(input logic [7:0] b);
        @(posedge reg_clk);
        midi_byte  <= b;
        midi_valid <= 1'b1;
        @(posedge reg_clk);
        midi_valid <= 1'b0;
    endtask

    task automatic write_reg(input logic [6:0] a, input logic [7:0] d);
        @(posedge reg_clk);
        cpu_write     <= 1'b1;
        address       <= a;
        cpu_writedata <= d;
        @(posedge reg_clk);
        cpu_write <= 1'b0;
        model_reg_write(a, d);
    endtask

    task automatic read_and_compare(input logic [6:0] a);
        @(posedge reg_clk);
        cpu_read <= 1'b1;
        address  <= a;
        @(posedge reg_clk);
        cpu_read <= 1'b0;
        @(negedge reg_clk);
        compare($sformatf("cpu_readdata[%0d]", a), cpu_readdata,
                (a < 7'd5) ? preg[a] : 8'h00);
    endtask

    // status 0 = keep running status
    task automatic play_note(input logic [7:0] status, input logic [6:0] key,
                             input logic [6:0] vel);
        logic [NV-1:0] exp_on;
        int            n;
        if (status != 8'h00) begin
            send_byte(status);
            run_status = status;
        end
        send_byte({1'b0, key});
        send_byte({1'b0, vel});
        track_note(key, vel);
        @(posedge reg_clk);   // note_valid, table updates on the next edge
        @(negedge reg_clk);
        n = 0;
        for (int v = 0; v < NV; v++) begin
            exp_on[v] = mon[v];
            n += mon[v];
        end
        compare("keys_on", keys_on, exp_on);
        compare("active_keys", active_keys, n);
    endtask

    task automatic sysex_write(input logic [6:0] a, input logic [6:0] d);
        send_byte(8'hF0);
        send_byte({1'b0, a});
        send_byte({1'b0, d});
        send_byte(8'hF7);
        run_status = 8'hF0;   // running status gone
        model_reg_write(a, {1'b0, d});
    endtask

    ////////////////////
    // one frame: expected mix from the model, then trig and compare
    task automatic run_frame(input string tag);
        longint mix;
        longint amp;
        longint s;
        longint l;
        longint r;
        int     n;
        mix = 0;
        for (int v = 0; v < NV; v++) begin
            if (mon[v]) begin
                amp = longint'(mvel[v]) * longint'(preg[1]);
                if (preg[0][0])
                    s = (amp * longint'($signed(mph[v][15:8]))) >>> 7;   // saw
                else
                    s = mph[v][15] ? -amp : amp;                         // square
                mix += s;
                mph[v] = mph[v] + (16'(mkey[v]) << `SYN_PHASE_SHIFT);
            end else begin
                mph[v] = 16'd0;
            end
        end
        l = (mix * longint'(preg[2])) >>> 8;
        r = (mix * longint'(preg[3])) >>> 8;
        @(posedge reg_clk);
        trig <= 1'b1;
        @(posedge reg_clk);
        trig <= 1'b0;
        n = 0;
        @(negedge reg_clk);
        while (frame_done !== 1'b1 && n < NV + 4) begin
            @(negedge reg_clk);
            n++;
        end
        if (frame_done !== 1'b1) begin
            errors++;
            $display("%s: frame_done never came after trig", tag);
        end else begin
            compare({tag, " lsound_out"}, lsound_out, l[23:0]);
            compare({tag, " rsound_out"}, rsound_out, r[23:0]);
        end
    endtask

    ////////////////////
    // directed tests
    task automatic reset_values();
        @(negedge reg_clk);
        compare("keys_on", keys_on, 0);
        compare("active_keys", active_keys, 0);
        compare("lsound_out", lsound_out, 0);
        compare("rsound_out", rsound_out, 0);
        compare("frame_done", frame_done, 0);
        for (int a = 0; a < 5; a++)
            read_and_compare(7'(a));
        report_test("reset values");
    endtask

    task automatic cpu_register_access();
        write_reg(7'd1, 8'h5A);
        write_reg(7'd2, 8'hC3);
        write_reg(7'd3, 8'h3C);
        write_reg(7'd0, 8'hFF);    // only the wave bit sticks
        write_reg(7'd4, 8'hA7);    // channel 7
        write_reg(7'd20, 8'hAA);   // outside the map
        for (int a = 0; a < 6; a++)
            read_and_compare(7'(a));
        read_and_compare(7'd20);
        read_and_compare(7'h7F);
        write_reg(7'd4, 8'h00);    // back to channel 0
        read_and_compare(7'd4);
        report_test("cpu register access");
    endtask

    task automatic note_allocation();
        play_note(8'h90, 7'd40, random_velocity());
        for (int k = 41; k < 48; k++)
            play_note(8'h00, 7'(k), random_velocity());
        play_note(8'h00, 7'd60, random_velocity());   // ninth, all voices busy
        play_note(8'h91, 7'd61, random_velocity());   // other channel
        play_note(8'h90, 7'd42, 7'd0);                // vel 0 frees voice 2
        play_note(8'h80, 7'd45, 7'h40);               // frees voice 5
        play_note(8'h90, 7'd40, random_velocity());   // already sounding
        play_note(8'h00, 7'd70, random_velocity());   // lands in voice 2
        for (int v = 0; v < NV; v++) begin
            if (mon[v])
                play_note(8'h80, mkey[v], 7'd0);
        end
        report_test("note allocation");
    endtask

    task automatic sysex_access();
        sysex_write(7'd1, 7'h33);
        read_and_compare(7'd1);
        sysex_write(7'd2, 7'h44);
        cpu_write     <= 1'b1;     // same cycle as the sysex request
        address       <= 7'd3;
        cpu_writedata <= 8'h99;
        @(posedge reg_clk);
        cpu_write <= 1'b0;
        model_reg_write(7'd3, 8'h99);
        read_and_compare(7'd2);
        read_and_compare(7'd3);
        read_and_compare(7'd1);
        report_test("sysex access");
    endtask

    task automatic square_frames();
        write_reg(7'd0, 8'h00);
        write_reg(7'd1, 8'h60);
        write_reg(7'd2, 8'hFF);
        write_reg(7'd3, 8'h40);
        play_note(8'h90, 7'h70, random_velocity());
        for (int f = 0; f < 12; f++)    // phase top bit flips around frame 5
            run_frame($sformatf("square frame %0d", f));
        report_test("square frames");
    endtask

    task automatic two_voice_saw();
        play_note(8'h00, 7'h25, random_velocity());
        for (int f = 0; f < 3; f++)
            run_frame($sformatf("two notes frame %0d", f));
        write_reg(7'd0, 8'h01);   // saw
        write_reg(7'd2, 8'h80);
        write_reg(7'd3, 8'hC0);
        for (int f = 0; f < 4; f++)
            run_frame($sformatf("saw frame %0d", f));
        play_note(8'h80, 7'h70, 7'd0);
        play_note(8'h00, 7'h25, 7'd0);
        run_frame("silent frame");
        report_test("two voice saw");
    endtask

    initial begin
        midi_byte     = 8'h00;
        midi_valid    = 1'b0;
        cpu_write     = 1'b0;
        cpu_read      = 1'b0;
        address       = '0;
        cpu_writedata = 8'h00;
        trig          = 1'b0;
        preg[0]       = 8'h00;   // square
        preg[1]       = 8'h80;
        preg[2]       = 8'hFF;
        preg[3]       = 8'hFF;
        preg[4]       = 8'h00;
        run_status    = 8'h00;
        for (int v = 0; v < NV; v++) begin
            mon[v] = 1'b0;
            mph[v] = 16'd0;
        end
        wait (arst_n === 1'b1);
        reset_values();
        cpu_register_access();
        note_allocation();
        sysex_access();
        square_frames();
        two_voice_saw();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* tb_clock.sv */
/*
 * testbench clock (100 ns) and reset held low for 10 cycles
 */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;   // release away from the active edge
    end

endmodule

/* voice_allocator.sv */
/*
 * note-to-voice table: lowest free voice on note-on, match on note-off,
 * keys_on bitmap and registered active-key count
 */
`timescale 1ns/1ps
`include "synth_cfg.svh"

module voice_allocator (
    input  logic                                reg_clk,
    input  logic                                arst_n,
    input  synth_pkg::note_evt_t                note,
    input  logic                                note_valid,
    output logic [`SYN_VOICES-1:0]              keys_on,
    output logic [`SYN_V_WIDTH:0]               active_keys,
    output logic [`SYN_VOICES-1:0][6:0]         key_tab,
    output logic [`SYN_VOICES-1:0][6:0]         vel_tab
);

    typedef logic [`SYN_V_WIDTH-1:0] vidx_t;

    vidx_t free_idx;
    vidx_t hit_idx;
    logic  any_free;
    logic  hit;       // key already held by some voice
    logic  do_on;
    logic  do_off;

    // scan high to low so the last match is the lowest voice
    always_comb begin
        free_idx = '0;
        hit_idx  = '0;
        any_free = 1'b0;
        hit      = 1'b0;
        for (int i = `SYN_VOICES - 1; i >= 0; i--) begin
            if (!keys_on[i]) begin
                free_idx = vidx_t'(i);
                any_free = 1'b1;
            end
            if (keys_on[i] && key_tab[i] == note.key) begin
                hit_idx = vidx_t'(i);
                hit     = 1'b1;
            end
        end
    end

    assign do_on  = note_valid &  note.on & any_free & ~hit;   // full or duplicate -> drop
    assign do_off = note_valid & ~note.on & hit;

    always_ff @(posedge reg_clk or negedge arst_n) begin
        if (!arst_n) begin
            keys_on     <= '0;
            active_keys <= '0;
        end else if (do_on) begin
            keys_on[free_idx] <= 1'b1;
            active_keys       <= active_keys + 1'b1;
        end else if (do_off) begin
            keys_on[hit_idx] <= 1'b0;
            active_keys      <= active_keys - 1'b1;
        end
    end

    // tables only meaningful where keys_on is set
    always_ff @(posedge reg_clk) begin
        if (do_on) begin
            key_tab[free_idx] <= note.key;
            vel_tab[free_idx] <= note.vel;
        end
    end

endmodule

/* voice_engine.sv */
/*
 * time-multiplexed voice engine: one voice per cycle after trig,
 * square / saw oscillator, velocity x level, mix, L/R gain
 */
`timescale 1ns/1ps
`include "synth_cfg.svh"

module voice_engine (
    input  logic                        reg_clk,
    input  logic                        arst_n,
    input  logic                        trig,
    input  logic [`SYN_VOICES-1:0]      keys_on,
    input  logic [`SYN_VOICES-1:0][6:0] key_tab,
    input  logic [`SYN_VOICES-1:0][6:0] vel_tab,
    input  synth_pkg::patch_t           patch,
    output logic [`SYN_AUD_BITS-1:0]    lsound_out,
    output logic [`SYN_AUD_BITS-1:0]    rsound_out,
    output logic                        frame_done
);

    localparam int PB = `SYN_PHASE_BITS;
    localparam int AB = `SYN_AUD_BITS;

    synth_pkg::eng_state_t state;

    logic [`SYN_V_WIDTH-1:0] vidx;                  // voice being visited
    logic [PB-1:0]           phase [`SYN_VOICES];
    logic signed [AB-1:0]    mix;

    logic [PB-1:0]           cur_phase;
    logic [PB-1:0]           inc;
    logic [14:0]             amp;                   // vel (7b) x level (8b)
    logic signed [15:0]      amp_s;
    logic signed [23:0]      saw_prod;
    logic signed [AB-1:0]    sq;
    logic signed [AB-1:0]    saw;
    logic signed [AB-1:0]    raw;
    logic signed [AB+8:0]    l_prod;
    logic signed [AB+8:0]    r_prod;

    ////////////////////
    // oscillator for the current voice
    always_comb begin
        cur_phase = phase[vidx];
        inc       = key_tab[vidx];                  // zero-extend first
        inc       = inc << `SYN_PHASE_SHIFT;
        amp       = 15'(vel_tab[vidx]) * 15'(patch.level);
        amp_s     = signed'({1'b0, amp});
        saw_prod  = amp_s * signed'(cur_phase[PB-1 -: 8]);
        sq        = amp_s;                          // sign-extended
        saw       = saw_prod >>> 7;
        if (!keys_on[vidx])
            raw = '0;
        else if (patch.wave == synth_pkg::WAVE_SAW)
            raw = saw;
        else
            raw = cur_phase[PB-1] ? -sq : sq;       // top bit picks half-cycle
    end

    // output gain, >>8 by taking the upper slice
    assign l_prod = mix * signed'({1'b0, patch.left_gain});
    assign r_prod = mix * signed'({1'b0, patch.right_gain});

    ////////////////////
    // frame sequencer
    always_ff @(posedge reg_clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= synth_pkg::ES_IDLE;
            vidx       <= '0;
            mix        <= '0;
            lsound_out <= '0;
            rsound_out <= '0;
            frame_done <= 1'b0;
            for (int i = 0; i < `SYN_VOICES; i++)
                phase[i] <= '0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                synth_pkg::ES_IDLE: begin
                    if (trig) begin                 // trig ignored elsewhere
                        state <= synth_pkg::ES_VOICE;
                        vidx  <= '0;
                        mix   <= '0;
                    end
                end
                synth_pkg::ES_VOICE: begin
                    mix <= mix + raw;
                    if (keys_on[vidx])
                        phase[vidx] <= cur_phase + inc;
                    else
                        phase[vidx] <= '0;          // idle voice restarts at 0
                    vidx <= vidx + 1'b1;
                    if (vidx == `SYN_V_WIDTH'(`SYN_VOICES - 1))
                        state <= synth_pkg::ES_OUT;
                end
                synth_pkg::ES_OUT: begin
                    lsound_out <= l_prod[AB+7:8];
                    rsound_out <= r_prod[AB+7:8];
                    frame_done <= 1'b1;
                    state      <= synth_pkg::ES_IDLE;
                end
                default: state <= synth_pkg::ES_IDLE;
            endcase
        end
    end

endmodule
